//--- logic/fir_cfg_pkg.sv
package fir_cfg_pkg;

    // control bus widths
    typedef logic [11:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t resp_okay = 2'b00;

    // register map, byte addresses
    localparam axil_addr_t addr_ap_ctrl     = 12'h000;
    localparam axil_addr_t addr_data_length = 12'h010;
    // tap i sits at addr_tap_base + 4*i
    localparam axil_addr_t addr_tap_base    = 12'h020;

    // ap_ctrl bit positions
    localparam int ctrl_start_bit = 0;
    localparam int ctrl_done_bit  = 1;
    localparam int ctrl_idle_bit  = 2;

    // idle after reset
    localparam axil_data_t ap_ctrl_reset_value = 32'h0000_0004;

endpackage

//--- logic/fir_dsp_pkg.sv
package fir_dsp_pkg;

    localparam int num_taps = 11;

    // datapath words, all wrap modulo 2^32
    typedef logic signed [31:0] sample_t;
    typedef logic signed [31:0] coef_t;
    typedef logic signed [31:0] acc_t;

    // tap or history slot
    typedef logic [3:0] tap_idx_t;

    localparam tap_idx_t last_tap = tap_idx_t'(num_taps - 1);

    // samples per run
    typedef logic [31:0] length_t;

    typedef enum logic [2:0] {
        eng_idle,
        eng_clear,
        eng_accept,
        eng_mac,
        eng_emit
    } eng_state_t;

endpackage

//--- logic/fir_ctrl_if.sv
`timescale 1ns/1ps

interface fir_ctrl_if;

    // from the register block
    logic                  start;
    fir_dsp_pkg::length_t  length;
    fir_dsp_pkg::coef_t    tap_coef;

    // from the engine
    fir_dsp_pkg::tap_idx_t tap_idx;
    logic                  first_taken;
    logic                  run_done;

    modport regs (
        output start,
        output length,
        output tap_coef,
        input  tap_idx,
        input  first_taken,
        input  run_done
    );

    modport engine (
        input  start,
        input  length,
        input  tap_coef,
        output tap_idx,
        output first_taken,
        output run_done
    );

endinterface

//--- logic/fir_axil_regs.sv
`timescale 1ns/1ps

module fir_axil_regs (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  logic                    awvalid,
    input  fir_cfg_pkg::axil_addr_t awaddr,
    output logic                    awready,
    input  logic                    wvalid,
    input  fir_cfg_pkg::axil_data_t wdata,
    output logic                    wready,
    output logic                    bvalid,
    output fir_cfg_pkg::axil_resp_t bresp,
    input  logic                    bready,
    input  logic                    arvalid,
    input  fir_cfg_pkg::axil_addr_t araddr,
    output logic                    arready,
    output logic                    rvalid,
    output fir_cfg_pkg::axil_data_t rdata,
    output fir_cfg_pkg::axil_resp_t rresp,
    input  logic                    rready,
    fir_ctrl_if.regs                ctrl
);

    logic                    ready_en;
    logic                    ap_start;
    logic                    ap_done;
    logic                    ap_idle;
    fir_dsp_pkg::length_t    data_length;
    fir_dsp_pkg::coef_t      coef_q [fir_dsp_pkg::num_taps];
    logic                    wr_fire;
    logic                    rd_fire;
    fir_cfg_pkg::axil_data_t rd_word;

    // word-aligned address inside the tap window
    function automatic logic is_tap(input fir_cfg_pkg::axil_addr_t addr);
        return (addr >= fir_cfg_pkg::addr_tap_base) &&
               (addr < fir_cfg_pkg::addr_tap_base + 4 * fir_dsp_pkg::num_taps) &&
               (addr[1:0] == 2'b00);
    endfunction

    function automatic fir_dsp_pkg::tap_idx_t tap_of(input fir_cfg_pkg::axil_addr_t addr);
        fir_cfg_pkg::axil_addr_t off;
        off = addr - fir_cfg_pkg::addr_tap_base;
        return off[5:2];
    endfunction

    // readies stay low for one cycle out of reset
    assign awready = ready_en & ~bvalid;
    assign wready  = ready_en & ~bvalid;
    assign arready = ready_en & ~rvalid;
    assign bresp   = fir_cfg_pkg::resp_okay;
    assign rresp   = fir_cfg_pkg::resp_okay;

    assign wr_fire = awvalid & wvalid & awready & wready;
    assign rd_fire = arvalid & arready;

    assign ctrl.start  = ap_start;
    assign ctrl.length = data_length;
    // engine walks taps 0..10, anything else reads as zero
    assign ctrl.tap_coef = (ctrl.tap_idx <= fir_dsp_pkg::last_tap) ?
                           coef_q[ctrl.tap_idx] : '0;

    always_comb begin
        rd_word = '0;
        if (araddr == fir_cfg_pkg::addr_ap_ctrl) begin
            rd_word[fir_cfg_pkg::ctrl_start_bit] = ap_start;
            rd_word[fir_cfg_pkg::ctrl_done_bit]  = ap_done;
            rd_word[fir_cfg_pkg::ctrl_idle_bit]  = ap_idle;
        end else if (araddr == fir_cfg_pkg::addr_data_length) begin
            rd_word = data_length;
        end else if (is_tap(araddr)) begin
            rd_word = coef_q[tap_of(araddr)];
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ready_en    <= 1'b0;
            bvalid      <= 1'b0;
            rvalid      <= 1'b0;
            ap_start    <= fir_cfg_pkg::ap_ctrl_reset_value[fir_cfg_pkg::ctrl_start_bit];
            ap_done     <= fir_cfg_pkg::ap_ctrl_reset_value[fir_cfg_pkg::ctrl_done_bit];
            ap_idle     <= fir_cfg_pkg::ap_ctrl_reset_value[fir_cfg_pkg::ctrl_idle_bit];
            data_length <= '0;
        end else begin
            ready_en <= 1'b1;

            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end

            if (wr_fire && awaddr == fir_cfg_pkg::addr_data_length) begin
                data_length <= wdata;
            end

            // start is only honoured while idle
            if (wr_fire && awaddr == fir_cfg_pkg::addr_ap_ctrl &&
                wdata[fir_cfg_pkg::ctrl_start_bit] && ap_idle) begin
                ap_start <= 1'b1;
                ap_idle  <= 1'b0;
            end else if (ctrl.first_taken) begin
                ap_start <= 1'b0;
            end

            // completion beats the read-to-clear of ap_done
            if (ctrl.run_done) begin
                ap_done <= 1'b1;
                ap_idle <= 1'b1;
            end else if (rd_fire && araddr == fir_cfg_pkg::addr_ap_ctrl) begin
                ap_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
        end
        // coefficients frozen while a run is active
        if (wr_fire && is_tap(awaddr) && ap_idle) begin
            coef_q[tap_of(awaddr)] <= wdata;
        end
    end

endmodule

//--- logic/fir_mac_engine.sv
`timescale 1ns/1ps

module fir_mac_engine (
    input  logic                 axis_clk,
    input  logic                 axis_rst_n,
    input  logic                 ss_tvalid,
    input  fir_dsp_pkg::sample_t ss_tdata,
    output logic                 ss_tready,
    output logic                 sm_tvalid,
    output fir_dsp_pkg::acc_t    sm_tdata,
    output logic                 sm_tlast,
    input  logic                 sm_tready,
    fir_ctrl_if.engine           ctrl
);

    fir_dsp_pkg::eng_state_t state;
    fir_dsp_pkg::sample_t    hist [fir_dsp_pkg::num_taps];
    // slot of the newest sample
    fir_dsp_pkg::tap_idx_t   head;
    fir_dsp_pkg::tap_idx_t   next_head;
    // history slot read for the current tap
    fir_dsp_pkg::tap_idx_t   rd_ptr;
    fir_dsp_pkg::tap_idx_t   tap_cnt;
    fir_dsp_pkg::acc_t       acc;
    fir_dsp_pkg::acc_t       prod_q;
    fir_dsp_pkg::length_t    out_cnt;
    logic                    ss_fire;
    logic                    sm_fire;
    logic                    run_done_q;

    assign ss_tready = (state == fir_dsp_pkg::eng_accept);
    assign ss_fire   = ss_tvalid & ss_tready;
    assign sm_fire   = sm_tvalid & sm_tready;
    assign next_head = (head == fir_dsp_pkg::last_tap) ? '0 : head + 1'b1;

    assign ctrl.tap_idx     = tap_cnt;
    assign ctrl.first_taken = ss_fire & (out_cnt == '0);
    assign ctrl.run_done    = run_done_q;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state      <= fir_dsp_pkg::eng_idle;
            head       <= '0;
            rd_ptr     <= '0;
            tap_cnt    <= '0;
            out_cnt    <= '0;
            sm_tvalid  <= 1'b0;
            sm_tlast   <= 1'b0;
            run_done_q <= 1'b0;
        end else begin
            run_done_q <= 1'b0;
            case (state)
                fir_dsp_pkg::eng_idle: begin
                    if (ctrl.start) begin
                        state <= fir_dsp_pkg::eng_clear;
                    end
                end
                fir_dsp_pkg::eng_clear: begin
                    // first sample of the run lands in slot 0
                    head    <= fir_dsp_pkg::last_tap;
                    out_cnt <= '0;
                    state   <= fir_dsp_pkg::eng_accept;
                end
                fir_dsp_pkg::eng_accept: begin
                    if (ss_fire) begin
                        head    <= next_head;
                        rd_ptr  <= next_head;
                        tap_cnt <= '0;
                        state   <= fir_dsp_pkg::eng_mac;
                    end
                end
                fir_dsp_pkg::eng_mac: begin
                    // step back one sample per tap
                    rd_ptr <= (rd_ptr == '0) ? fir_dsp_pkg::last_tap : rd_ptr - 1'b1;
                    if (tap_cnt == fir_dsp_pkg::last_tap) begin
                        tap_cnt <= '0;
                        state   <= fir_dsp_pkg::eng_emit;
                    end else begin
                        tap_cnt <= tap_cnt + 1'b1;
                    end
                end
                fir_dsp_pkg::eng_emit: begin
                    if (!sm_tvalid) begin
                        sm_tvalid <= 1'b1;
                        sm_tlast  <= (out_cnt == ctrl.length - 1'b1);
                    end else if (sm_fire) begin
                        sm_tvalid <= 1'b0;
                        sm_tlast  <= 1'b0;
                        out_cnt   <= out_cnt + 1'b1;
                        if (sm_tlast) begin
                            run_done_q <= 1'b1;
                            state      <= fir_dsp_pkg::eng_idle;
                        end else begin
                            state <= fir_dsp_pkg::eng_accept;
                        end
                    end
                end
                default: begin
                    state <= fir_dsp_pkg::eng_idle;
                end
            endcase
        end
    end

    // history ring and MAC datapath
    always_ff @(posedge axis_clk) begin
        if (state == fir_dsp_pkg::eng_clear) begin
            for (int i = 0; i < fir_dsp_pkg::num_taps; i++) begin
                hist[i] <= '0;
            end
        end else if (ss_fire) begin
            hist[next_head] <= ss_tdata;
        end

        // product is registered, sum trails it by a cycle
        if (state == fir_dsp_pkg::eng_mac) begin
            prod_q <= ctrl.tap_coef * hist[rd_ptr];
        end

        if (ss_fire) begin
            acc <= '0;
        end else if (state == fir_dsp_pkg::eng_mac && tap_cnt != '0) begin
            acc <= acc + prod_q;
        end

        // fold in the last product when the result is loaded
        if (state == fir_dsp_pkg::eng_emit && !sm_tvalid) begin
            sm_tdata <= acc + prod_q;
        end
    end

endmodule

//--- logic/fir_top.sv
`timescale 1ns/1ps

module fir_top (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  logic                    awvalid,
    input  fir_cfg_pkg::axil_addr_t awaddr,
    output logic                    awready,
    input  logic                    wvalid,
    input  fir_cfg_pkg::axil_data_t wdata,
    output logic                    wready,
    output logic                    bvalid,
    output fir_cfg_pkg::axil_resp_t bresp,
    input  logic                    bready,
    input  logic                    arvalid,
    input  fir_cfg_pkg::axil_addr_t araddr,
    output logic                    arready,
    output logic                    rvalid,
    output fir_cfg_pkg::axil_data_t rdata,
    output fir_cfg_pkg::axil_resp_t rresp,
    input  logic                    rready,
    input  logic                    ss_tvalid,
    input  fir_dsp_pkg::sample_t    ss_tdata,
    output logic                    ss_tready,
    output logic                    sm_tvalid,
    output fir_dsp_pkg::acc_t       sm_tdata,
    output logic                    sm_tlast,
    input  logic                    sm_tready
);

    // register block to engine link
    fir_ctrl_if ctrl_bus ();

    fir_axil_regs u_regs (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .bvalid     (bvalid),
        .bresp      (bresp),
        .bready     (bready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rresp      (rresp),
        .rready     (rready),
        .ctrl       (ctrl_bus.regs)
    );

    fir_mac_engine u_engine (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tready  (ss_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .sm_tready  (sm_tready),
        .ctrl       (ctrl_bus.engine)
    );

endmodule

//--- bench/fir_props.sv
`timescale 1ns/1ps

module fir_props (
    input logic        axis_clk,
    input logic        axis_rst_n,
    input logic        awvalid,
    input logic        awready,
    input logic        wvalid,
    input logic        wready,
    input logic        bvalid,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input logic        ss_tready,
    input logic        sm_tvalid,
    input logic        sm_tready,
    input logic [31:0] sm_tdata
);

    int assert_failures;

    initial begin
        assert_failures = 0;
    end

    // stalled output beat must not move
    out_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata))
    else begin
        $error("sm_tvalid or sm_tdata changed before sm_tready");
        assert_failures++;
    end

    // one sample in flight at a time
    stream_excl: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        !(ss_tready && sm_tvalid))
    else begin
        $error("ss_tready and sm_tvalid high together");
        assert_failures++;
    end

    write_resp: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        awvalid && awready && wvalid && wready |=> bvalid)
    else begin
        $error("bvalid missing the cycle after a write handshake");
        assert_failures++;
    end

    read_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
        $error("rvalid or rdata changed before rready");
        assert_failures++;
    end

endmodule

bind fir_top fir_props u_props (.*);

//--- bench/fir_tb.sv
`timescale 1ns/1ps

module fir_tb;

    logic                    axis_clk;
    logic                    axis_rst_n;
    logic                    awvalid;
    fir_cfg_pkg::axil_addr_t awaddr;
    logic                    awready;
    logic                    wvalid;
    fir_cfg_pkg::axil_data_t wdata;
    logic                    wready;
    logic                    bvalid;
    fir_cfg_pkg::axil_resp_t bresp;
    logic                    bready;
    logic                    arvalid;
    fir_cfg_pkg::axil_addr_t araddr;
    logic                    arready;
    logic                    rvalid;
    fir_cfg_pkg::axil_data_t rdata;
    fir_cfg_pkg::axil_resp_t rresp;
    logic                    rready;
    logic                    ss_tvalid;
    logic [31:0]             ss_tdata;
    logic                    ss_tready;
    logic                    sm_tvalid;
    logic [31:0]             sm_tdata;
    logic                    sm_tlast;
    logic                    sm_tready;

    // data file contents
    logic [31:0] taps [fir_dsp_pkg::num_taps];
    logic [31:0] data_len;
    logic [31:0] samples [$];
    logic [31:0] expected [$];
    bit          file_ok;

    int          error_count = 0;
    int          test_start_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    int          timeout_limit = 2000;
    int          sent_count;
    bit          midrun_write_done;
    logic [31:0] rd_val;

    fir_top u_fir_top (.*);

    initial begin
        axis_clk = 1'b0;
        forever #5 axis_clk = ~axis_clk;
    end

    always @(posedge axis_clk) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            $display("timeout after %0d cycles, a handshake never completed", cycle_count);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
        error_count++;
    endtask

    task automatic finish_test(input int num, input string name);
        tests_run++;
        if (error_count == test_start_errors) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, error_count - test_start_errors);
        end
        test_start_errors = error_count;
    endtask

    task automatic load_input_file();
        int          fd;
        int          code;
        string       line;
        logic [7:0]  tag;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("bench/fir_input.txt", "r");
        file_ok = (fd != 0);
        if (!file_ok) begin
            $display("could not open bench/fir_input.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%c %h %h", tag, a, b);
                    case (tag)
                        "t": taps[a[3:0]] = b;
                        "l": data_len = a;
                        "s": begin
                            samples.push_back(a);
                            expected.push_back(b);
                        end
                        default: $display("skipped unknown line in data file: %s", line);
                    endcase
                end
            end
            $fclose(fd);
            if (samples.size() != data_len) begin
                $display("data file length does not match its sample count");
                file_ok = 1'b0;
            end
        end
    endtask

    // called on a falling edge and returns on one
    task automatic axil_write(input fir_cfg_pkg::axil_addr_t addr,
                              input fir_cfg_pkg::axil_data_t data);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        bready  = 1'b1;
        while (!(awready && wready)) @(negedge axis_clk);
        @(negedge axis_clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (!bvalid) begin
            $display("** Error: no write response the cycle after writing 0x%03h", addr);
            error_count++;
        end
        while (!bvalid) @(negedge axis_clk);
        if (bresp !== 2'b00) begin
            report_mismatch("bresp", bresp, 2'b00);
        end
        @(negedge axis_clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input fir_cfg_pkg::axil_addr_t addr,
                             output logic [31:0] data);
        arvalid = 1'b1;
        araddr  = addr;
        while (!arready) @(negedge axis_clk);
        @(negedge axis_clk);
        arvalid = 1'b0;
        rready  = 1'b1;
        while (!rvalid) @(negedge axis_clk);
        data = rdata;
        if (rresp !== 2'b00) begin
            report_mismatch("rresp", rresp, 2'b00);
        end
        @(negedge axis_clk);
        rready = 1'b0;
    endtask

    // feeds all samples and checks every output beat
    task automatic run_stream(input bit jitter, input bit poke_tap);
        int got;
        bit last_exp;
        sent_count = 0;
        got = 0;
        fork
            begin
                for (int i = 0; i < samples.size(); i++) begin
                    if (jitter) begin
                        repeat ($urandom % 4) @(negedge axis_clk);
                    end
                    ss_tvalid = 1'b1;
                    ss_tdata  = samples[i];
                    while (!ss_tready) @(negedge axis_clk);
                    @(negedge axis_clk);
                    ss_tvalid = 1'b0;
                    sent_count++;
                end
            end
            begin
                while (got < samples.size()) begin
                    @(negedge axis_clk);
                    sm_tready = jitter ? ($urandom % 3 != 0) : 1'b1;
                    if (sm_tvalid && sm_tready) begin
                        last_exp = (got == samples.size() - 1);
                        if (sm_tdata !== expected[got]) begin
                            report_mismatch($sformatf("sm_tdata[%0d]", got), sm_tdata,
                                            expected[got]);
                        end
                        if (sm_tlast !== last_exp) begin
                            report_mismatch($sformatf("sm_tlast[%0d]", got), sm_tlast, last_exp);
                        end
                        got++;
                    end
                end
                @(negedge axis_clk);
                sm_tready = 1'b0;
            end
            begin
                // coefficient change mid run that must be dropped
                if (poke_tap) begin
                    wait (sent_count >= 3);
                    @(negedge axis_clk);
                    axil_write(fir_cfg_pkg::addr_tap_base, 32'h0000_0064);
                    midrun_write_done = 1'b1;
                end
            end
        join
    endtask

    task automatic wait_done();
        logic [31:0] ctrl_word;
        ctrl_word = '0;
        while (!ctrl_word[fir_cfg_pkg::ctrl_done_bit]) begin
            axil_read(fir_cfg_pkg::addr_ap_ctrl, ctrl_word);
        end
        if (ctrl_word !== 32'h6) begin
            report_mismatch("ap_ctrl after run", ctrl_word, 32'h6);
        end
        // ap_done clears on read
        axil_read(fir_cfg_pkg::addr_ap_ctrl, ctrl_word);
        if (ctrl_word !== 32'h4) begin
            report_mismatch("ap_ctrl second read", ctrl_word, 32'h4);
        end
    endtask

    initial begin
        axis_rst_n        = 1'b0;
        awvalid           = 1'b0;
        awaddr            = '0;
        wvalid            = 1'b0;
        wdata             = '0;
        bready            = 1'b0;
        arvalid           = 1'b0;
        araddr            = '0;
        rready            = 1'b0;
        ss_tvalid         = 1'b0;
        ss_tdata          = '0;
        sm_tready         = 1'b0;
        midrun_write_done = 1'b0;
        void'($urandom(21));
        load_input_file();
        if (!file_ok) begin
            $display("Result: FAILED");
            $finish;
        end else begin
            timeout_limit = 2 * data_len * 40 + 2000;
            repeat (4) @(posedge axis_clk);
            @(negedge axis_clk);
            axis_rst_n = 1'b1;

            if (ss_tready !== 1'b0) begin
                report_mismatch("ss_tready", ss_tready, 32'h0);
            end
            if (sm_tvalid !== 1'b0) begin
                report_mismatch("sm_tvalid", sm_tvalid, 32'h0);
            end
            if (awready !== 1'b0) begin
                report_mismatch("awready", awready, 32'h0);
            end
            if (wready !== 1'b0) begin
                report_mismatch("wready", wready, 32'h0);
            end
            if (arready !== 1'b0) begin
                report_mismatch("arready", arready, 32'h0);
            end
            axil_read(fir_cfg_pkg::addr_ap_ctrl, rd_val);
            if (rd_val !== 32'h4) begin
                report_mismatch("ap_ctrl", rd_val, 32'h4);
            end
            finish_test(1, "reset state");

            for (int i = 0; i < fir_dsp_pkg::num_taps; i++) begin
                axil_write(fir_cfg_pkg::addr_tap_base + 4 * i, taps[i]);
            end
            axil_write(fir_cfg_pkg::addr_data_length, data_len);
            for (int i = 0; i < fir_dsp_pkg::num_taps; i++) begin
                axil_read(fir_cfg_pkg::addr_tap_base + 4 * i, rd_val);
                if (rd_val !== taps[i]) begin
                    report_mismatch($sformatf("rdata tap %0d", i), rd_val, taps[i]);
                end
            end
            axil_read(fir_cfg_pkg::addr_data_length, rd_val);
            if (rd_val !== data_len) begin
                report_mismatch("rdata data_length", rd_val, data_len);
            end
            axil_read(12'h008, rd_val);
            if (rd_val !== 32'h0) begin
                report_mismatch("rdata unmapped 0x008", rd_val, 32'h0);
            end
            finish_test(2, "register write and read back");

            axil_write(fir_cfg_pkg::addr_ap_ctrl, 32'h1);
            axil_read(fir_cfg_pkg::addr_ap_ctrl, rd_val);
            if (rd_val !== 32'h1) begin
                report_mismatch("ap_ctrl after start", rd_val, 32'h1);
            end
            finish_test(3, "start flags");

            run_stream(1'b0, 1'b0);
            wait_done();
            finish_test(4, "first run");

            axil_write(fir_cfg_pkg::addr_ap_ctrl, 32'h1);
            run_stream(1'b1, 1'b1);
            wait_done();
            finish_test(5, "second run with stalls");

            if (!midrun_write_done) begin
                $display("** Error: the tap write during the second run never completed");
                error_count++;
            end
            axil_read(fir_cfg_pkg::addr_tap_base, rd_val);
            if (rd_val !== taps[0]) begin
                report_mismatch("rdata tap 0 after run", rd_val, taps[0]);
            end
            finish_test(6, "tap write during run ignored");

            $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                     tests_run, tests_failed, error_count, u_fir_top.u_props.assert_failures);
            if (error_count == 0 && u_fir_top.u_props.assert_failures == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end

endmodule

//--- fir_filter.f
logic/fir_cfg_pkg.sv
logic/fir_dsp_pkg.sv
logic/fir_ctrl_if.sv
logic/fir_axil_regs.sv
logic/fir_mac_engine.sv
logic/fir_top.sv
bench/fir_props.sv
bench/fir_tb.sv

//--- bench/fir_input.txt
# t: tap index and coefficient, l: sample count, s: sample and expected output
# all values hex, negatives as 32-bit two's complement
t 0 00000001
t 1 00000002
t 2 ffffffff
t 3 00000003
t 4 00000000
t 5 fffffffe
t 6 00000004
t 7 00000001
t 8 fffffffd
t 9 00000002
t a 00000005
l 00000010
s 00000001 00000001
s 00000000 00000002
s 00000000 ffffffff
s 00000002 00000005
s 00000000 00000004
s ffffffff fffffffb
s 00000000 00000008
s 00000000 00000002
s 00000000 fffffff6
s 00000000 0000000a
s 00000000 00000009
s 00000000 fffffff6
s 40000000 40000003
s 00000000 8000000d
s 00000000 bffffffe
s 00000003 bffffffe
